//--- Bender.yml
package:
  name: soc_fabric

sources:
  # Package first, then leaf modules, then the top
  - files:
      - design/soc_pkg.sv
      - design/ram_line_store.sv
      - design/wb_addr_decoder.sv
      - design/wb_ram_adapter.sv
      - design/wb_clint.sv
      - design/soc_fabric_top.sv

  # Testbench, top module tb_soc_fabric
  - target: test
    files:
      - dv/tb_soc_fabric.sv

//--- design/ram_line_store.sv
/* Line-wide RAM array with byte-strobe writes and a fixed-latency
   read pipeline that models slow external memory */
module ram_line_store (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  soc_pkg::line_idx_t  line_idx_i,
  input  soc_pkg::line_t      line_wdata_i,
  input  soc_pkg::line_strb_t line_strb_i,
  input  logic                rd_pulse_i,
  output soc_pkg::line_t      line_rdata_o,
  output logic                line_valid_o
);
  import soc_pkg::*;

  line_t                  mem_q  [RAM_LINES];
  // Data and valid travel side by side
  line_t                  data_q [RAM_LATENCY];
  logic [RAM_LATENCY-1:0] valid_q;

  // Byte-strobe write port
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < LINE_STRB_W; b++) begin
      if (line_strb_i[b]) begin
        mem_q[line_idx_i][b*8 +: 8] <= line_wdata_i[b*8 +: 8];
      end
    end
  end

  // ==================================================
  // Read pipeline
  // ==================================================
  // Several reads may be in flight
  always_ff @(posedge clk_i) begin
    if (rd_pulse_i) begin
      data_q[0] <= mem_q[line_idx_i];
    end
    for (int s = 1; s < RAM_LATENCY; s++) begin
      data_q[s] <= data_q[s-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[RAM_LATENCY-2:0], rd_pulse_i};
    end
  end

  // Last stage, RAM_LATENCY cycles after the pulse
  assign line_rdata_o = data_q[RAM_LATENCY-1];
  assign line_valid_o = valid_q[RAM_LATENCY-1];

endmodule

//--- design/soc_fabric_top.sv
/* Fabric top: address decoder, RAM adapter with its line store, and CLINT */
module soc_fabric_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  output logic             timer_irq_o,
  output logic             sw_irq_o
);
  import soc_pkg::*;

  // Decoder to slaves
  wb_req_t    ram_req;
  wb_rsp_t    ram_rsp;
  wb_req_t    clint_req;
  wb_rsp_t    clint_rsp;
  // Adapter to line store
  line_idx_t  line_idx;
  line_t      line_wdata;
  line_strb_t line_strb;
  logic       rd_pulse;
  line_t      line_rdata;
  logic       line_valid;

  wb_addr_decoder wb_addr_decoder_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .m_req_i     (wb_req_i),
    .m_rsp_o     (wb_rsp_o),
    .ram_req_o   (ram_req),
    .ram_rsp_i   (ram_rsp),
    .clint_req_o (clint_req),
    .clint_rsp_i (clint_rsp)
  );

  // ==================================================
  // RAM slave
  // ==================================================
  wb_ram_adapter wb_ram_adapter_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (ram_req),
    .rsp_o        (ram_rsp),
    .line_idx_o   (line_idx),
    .line_wdata_o (line_wdata),
    .line_strb_o  (line_strb),
    .rd_pulse_o   (rd_pulse),
    .line_rdata_i (line_rdata),
    .line_valid_i (line_valid)
  );

  ram_line_store ram_line_store_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .line_idx_i   (line_idx),
    .line_wdata_i (line_wdata),
    .line_strb_i  (line_strb),
    .rd_pulse_i   (rd_pulse),
    .line_rdata_o (line_rdata),
    .line_valid_o (line_valid)
  );

  // CLINT slave
  wb_clint wb_clint_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (clint_req),
    .rsp_o       (clint_rsp),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

endmodule

//--- design/soc_pkg.sv
/* Shared package: bus widths, Wishbone request and response structs, cycle-type
   codes, address map, RAM geometry and CLINT register offsets */
package soc_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int unsigned ADDR_W         = 32;
  localparam int unsigned DATA_W         = 32;
  localparam int unsigned SEL_W          = DATA_W / 8;
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam int unsigned LINE_W         = WORDS_PER_LINE * DATA_W;
  localparam int unsigned LINE_STRB_W    = LINE_W / 8;
  // Byte address split: word offset, then line offset
  localparam int unsigned WORD_LSB       = $clog2(SEL_W);
  localparam int unsigned WORD_OFS_W     = $clog2(WORDS_PER_LINE);
  localparam int unsigned LINE_OFS_W     = $clog2(LINE_STRB_W);

  // RAM geometry, 1024 lines of 16 bytes
  localparam int unsigned RAM_LINES   = 1024;
  localparam int unsigned RAM_LATENCY = 16;
  localparam int unsigned RAM_IDX_W   = $clog2(RAM_LINES);

  // CLINT register window
  localparam int unsigned CLINT_OFS_W = 16;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [SEL_W-1:0]       sel_t;
  typedef logic [LINE_W-1:0]      line_t;
  typedef logic [LINE_STRB_W-1:0] line_strb_t;
  typedef logic [RAM_IDX_W-1:0]   line_idx_t;
  typedef logic [2:0]             cti_t;
  typedef logic [CLINT_OFS_W-1:0] clint_ofs_t;

  // ==================================================
  // Wishbone B4 structs
  // ==================================================
  // Master to slave, 74 bits
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
    sel_t  sel;
    cti_t  cti;
  } wb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    data_t dat;
    logic  ack;
    logic  err;
  } wb_rsp_t;

  // Cycle-type codes
  localparam cti_t CTI_CLASSIC = 3'b000;
  localparam cti_t CTI_INCR    = 3'b010;
  localparam cti_t CTI_EOB     = 3'b111;

  // ==================================================
  // Address map
  // ==================================================
  localparam addr_t RAM_BASE   = 32'h8000_0000;
  localparam addr_t CLINT_BASE = 32'h3000_0000;
  localparam int unsigned REGION_MSB = 31;
  localparam int unsigned REGION_LSB = 28;

  // CLINT offsets, high words sit at +4
  localparam clint_ofs_t CLINT_MSIP_OFS     = 16'h0000;
  localparam clint_ofs_t CLINT_MTIMECMP_OFS = 16'h4000;
  localparam clint_ofs_t CLINT_MTIME_OFS    = 16'hBFF8;

endpackage

//--- design/wb_addr_decoder.sv
/* Region decoder: routes the master request to RAM or CLINT, muxes the
   response back and answers unmapped addresses with err */
module wb_addr_decoder (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t m_req_i,
  output soc_pkg::wb_rsp_t m_rsp_o,
  output soc_pkg::wb_req_t ram_req_o,
  input  soc_pkg::wb_rsp_t ram_rsp_i,
  output soc_pkg::wb_req_t clint_req_o,
  input  soc_pkg::wb_rsp_t clint_rsp_i
);
  import soc_pkg::*;

  logic live;
  logic hit_ram;
  logic hit_clint;
  logic sel_ram;
  logic sel_clint;
  // Open RAM burst, pins the route to RAM
  logic burst_q;

  assign live      = m_req_i.cyc && m_req_i.stb;
  // Top nibble picks the region
  assign hit_ram   = m_req_i.adr[REGION_MSB:REGION_LSB] == RAM_BASE[REGION_MSB:REGION_LSB];
  assign hit_clint = m_req_i.adr[REGION_MSB:REGION_LSB] == CLINT_BASE[REGION_MSB:REGION_LSB];
  assign sel_ram   = hit_ram || burst_q;
  assign sel_clint = hit_clint && !burst_q;

  // ==================================================
  // Request fan-out
  // ==================================================
  always_comb begin
    ram_req_o       = m_req_i;
    ram_req_o.stb   = m_req_i.stb && sel_ram;
    clint_req_o     = m_req_i;
    clint_req_o.stb = m_req_i.stb && sel_clint;
  end

  // Response mux, unmapped gets err in the same cycle
  always_comb begin
    if (sel_ram) begin
      m_rsp_o = ram_rsp_i;
    end else if (sel_clint) begin
      m_rsp_o = clint_rsp_i;
    end else begin
      m_rsp_o.dat = '0;
      m_rsp_o.ack = 1'b0;
      m_rsp_o.err = live;
    end
  end

  // Burst tracking
  // Set by an acked INCR read, cleared by the closing beat or cyc low
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      burst_q <= 1'b0;
    end else if (!m_req_i.cyc) begin
      burst_q <= 1'b0;
    end else if (live && sel_ram && ram_rsp_i.ack && !m_req_i.we) begin
      burst_q <= (m_req_i.cti == CTI_INCR);
    end
  end

  // Slaves never answer ack and err together
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(m_rsp_o.ack && m_rsp_o.err));

  // A mapped region never sees err on the master side
  a_no_err_mapped: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (live && (hit_ram || hit_clint)) |-> !m_rsp_o.err);

endmodule

//--- design/wb_clint.sv
/* CLINT: 64-bit mtime and mtimecmp, msip bit, registered Wishbone
   access and the timer and software interrupt outputs */
module wb_clint (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o,
  output logic             timer_irq_o,
  output logic             sw_irq_o
);
  import soc_pkg::*;

  logic        live;
  logic        acc;
  logic        wr;
  clint_ofs_t  ofs;
  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic        msip_q;
  logic        ack_q;
  data_t       rdata;
  data_t       rdata_q;

  // Byte-select merge of one word
  function automatic data_t merge_word(input data_t old_w, input data_t new_w, input sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign live = req_i.cyc && req_i.stb;
  // Ack cycle itself is not a new access
  assign acc  = live && !ack_q;
  assign wr   = acc && req_i.we;
  // Word-aligned offset in the window
  assign ofs  = {req_i.adr[CLINT_OFS_W-1:WORD_LSB], {WORD_LSB{1'b0}}};

  // ==================================================
  // Register read mux
  // ==================================================
  always_comb begin
    rdata = '0;
    case (ofs)
      CLINT_MSIP_OFS:                        rdata = {{(DATA_W-1){1'b0}}, msip_q};
      CLINT_MTIMECMP_OFS:                    rdata = mtimecmp_q[31:0];
      clint_ofs_t'(CLINT_MTIMECMP_OFS + 4):  rdata = mtimecmp_q[63:32];
      CLINT_MTIME_OFS:                       rdata = mtime_q[31:0];
      clint_ofs_t'(CLINT_MTIME_OFS + 4):     rdata = mtime_q[63:32];
      default:                               rdata = '0;
    endcase
  end

  // Free-running count, a write overrides its word
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    if (wr && ofs == CLINT_MTIME_OFS) begin
      mtime_d[31:0] = merge_word(mtime_q[31:0], req_i.dat, req_i.sel);
    end
    if (wr && ofs == clint_ofs_t'(CLINT_MTIME_OFS + 4)) begin
      mtime_d[63:32] = merge_word(mtime_q[63:32], req_i.dat, req_i.sel);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      mtime_q <= mtime_d;
      ack_q   <= acc;
      if (wr) begin
        case (ofs)
          CLINT_MSIP_OFS: begin
            if (req_i.sel[0]) begin
              msip_q <= req_i.dat[0];
            end
          end
          CLINT_MTIMECMP_OFS: begin
            mtimecmp_q[31:0] <= merge_word(mtimecmp_q[31:0], req_i.dat, req_i.sel);
          end
          clint_ofs_t'(CLINT_MTIMECMP_OFS + 4): begin
            mtimecmp_q[63:32] <= merge_word(mtimecmp_q[63:32], req_i.dat, req_i.sel);
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      rdata_q <= rdata;
    end
  end

  assign rsp_o.dat = rdata_q;
  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;

  // Unsigned 64-bit compare
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

  // Every ack answers the request still held from the cycle before
  a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.ack |-> (live && $stable(req_i.adr)));

endmodule

//--- design/wb_ram_adapter.sv
/* Wishbone to line adapter: write word placement, read FSM with one
   line fetch per burst, burst line buffer and ack generation */
module wb_ram_adapter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  soc_pkg::wb_req_t    req_i,
  output soc_pkg::wb_rsp_t    rsp_o,
  output soc_pkg::line_idx_t  line_idx_o,
  output soc_pkg::line_t      line_wdata_o,
  output soc_pkg::line_strb_t line_strb_o,
  output logic                rd_pulse_o,
  input  soc_pkg::line_t      line_rdata_i,
  input  logic                line_valid_i
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_LINE,
    ST_STREAM
  } state_e;

  state_e                state_q;
  state_e                state_d;
  logic                  live;
  logic                  wr_req;
  logic                  rd_req;
  logic [WORD_OFS_W-1:0] word_ofs;
  logic                  rd_pulse_q;
  logic                  line_ack;
  logic                  burst_ack;
  // Buffered line and its index
  line_t                 buf_q;
  line_idx_t             buf_idx_q;

  assign live       = req_i.cyc && req_i.stb;
  assign wr_req     = live && req_i.we;
  assign rd_req     = live && !req_i.we;
  assign word_ofs   = req_i.adr[WORD_LSB +: WORD_OFS_W];
  assign line_idx_o = req_i.adr[LINE_OFS_W +: RAM_IDX_W];

  // ==================================================
  // Write path
  // ==================================================
  // Word copied to every slot, strobes pick the slot
  always_comb begin
    line_strb_o = '0;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      line_wdata_o[w*DATA_W +: DATA_W] = req_i.dat;
    end
    if (wr_req) begin
      line_strb_o[word_ofs*SEL_W +: SEL_W] = req_i.sel;
    end
  end

  // ==================================================
  // Read FSM
  // ==================================================
  // First beat acks on the returning line
  assign line_ack  = (state_q == ST_WAIT_LINE) && line_valid_i && rd_req;
  // Later beats come straight from the buffer
  assign burst_ack = (state_q == ST_STREAM) && rd_req;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (rd_req) begin
          state_d = ST_WAIT_LINE;
        end
      end
      ST_WAIT_LINE: begin
        if (line_valid_i) begin
          // Stay on the line only for an incrementing burst
          state_d = (line_ack && req_i.cti == CTI_INCR) ? ST_STREAM : ST_IDLE;
        end
      end
      ST_STREAM: begin
        // EOB beat or a dropped cycle ends the burst
        if (!req_i.cyc || (burst_ack && req_i.cti != CTI_INCR)) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      rd_pulse_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      // One register stage behind the first live cycle
      rd_pulse_q <= (state_q == ST_IDLE) && rd_req;
    end
  end

  assign rd_pulse_o = rd_pulse_q;

  // Capture the line on the first beat
  always_ff @(posedge clk_i) begin
    if (line_ack) begin
      buf_q     <= line_rdata_i;
      buf_idx_q <= line_idx_o;
    end
  end

  // Response
  always_comb begin
    rsp_o.ack = wr_req || line_ack || burst_ack;
    rsp_o.err = 1'b0;
    if (state_q == ST_STREAM) begin
      rsp_o.dat = buf_q[word_ofs*DATA_W +: DATA_W];
    end else begin
      rsp_o.dat = line_rdata_i[word_ofs*DATA_W +: DATA_W];
    end
  end

  // Burst beats stay on the captured line
  a_beat_in_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == ST_STREAM && live) |-> (line_idx_o == buf_idx_q));

  // Master holds off writes until the read is done
  a_no_wr_in_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != ST_IDLE && live) |-> !req_i.we);

endmodule

//--- dv/tb_soc_fabric.sv
/* Testbench for the fabric top: clock and reset, Wishbone bus tasks, a RAM
   reference model, compare tasks, directed tests and a watchdog */
module tb_soc_fabric;
  timeunit 1ns;
  timeprecision 1ps;

  import soc_pkg::*;

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned RAND_WORDS   = 16;
  localparam int unsigned RAND_OPS     = 200;
  // Bus accesses per test, in run order
  localparam int unsigned N_ACCESS   = 11 + 10 + 2 + 4 + 7 + RAND_WORDS + RAND_OPS;
  localparam int unsigned TIMEOUT_NS = N_ACCESS * (RAM_LATENCY + 8) * CLK_PERIOD * 2;
  localparam addr_t       RAND_BASE  = RAM_BASE + 32'h0000_1000;

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        timer_irq;
  logic        sw_irq;
  int unsigned rand_seed;
  // Word-wide RAM model, indexed by word address
  data_t       ref_mem [RAM_LINES*WORDS_PER_LINE];
  data_t       burst_words [WORDS_PER_LINE];

  soc_fabric_top soc_fabric_top_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .timer_irq_o (timer_irq),
    .sw_irq_o    (sw_irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Watchdog, sized from the access count
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $fatal(1, "Simulation timed out");
  end

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "Flag mismatch");
    end
  endtask

  task automatic check_rsp_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: expected err %b, actual err %b", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "Bus error mismatch");
    end
  endtask

  // Byte-select merge as the bus defines it
  function automatic data_t apply_byte_sel(input data_t old_w, input data_t new_w,
                                           input sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic int unsigned word_index(input addr_t adr);
    addr_t ofs;
    ofs = adr - RAM_BASE;
    return ofs[13:2];
  endfunction

  function automatic addr_t clint_addr(input clint_ofs_t ofs);
    return CLINT_BASE + addr_t'(ofs);
  endfunction

  // ==================================================
  // Bus tasks
  // ==================================================
  task automatic bus_idle();
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  // Sample after the falling edge, return on the edge after the ack
  task automatic wait_response(output wb_rsp_t rsp);
    logic done;
    done = 1'b0;
    while (!done) begin
      #1;
      if (wb_rsp.ack || wb_rsp.err) begin
        rsp  = wb_rsp;
        done = 1'b1;
      end
      @(negedge clk);
    end
  endtask

  task automatic bus_single(input addr_t adr, input logic we, input data_t dat,
                            input sel_t sel, output wb_rsp_t rsp);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = sel;
    wb_req.cti = CTI_CLASSIC;
    wait_response(rsp);
    bus_idle();
  endtask

  // Incrementing burst over one line, EOB on the last beat
  task automatic read_burst(input string name, input addr_t base);
    wb_rsp_t rsp;
    @(negedge clk);
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b0;
      wb_req.adr = base + addr_t'(4*b);
      wb_req.dat = '0;
      wb_req.sel = '1;
      wb_req.cti = (b == WORDS_PER_LINE-1) ? CTI_EOB : CTI_INCR;
      wait_response(rsp);
      check_rsp_err(name, 1'b0, rsp.err);
      burst_words[b] = rsp.dat;
    end
    bus_idle();
  endtask

  task automatic ram_write(input string name, input addr_t adr, input data_t dat,
                           input sel_t sel);
    wb_rsp_t rsp;
    bus_single(adr, 1'b1, dat, sel, rsp);
    check_rsp_err(name, 1'b0, rsp.err);
    ref_mem[word_index(adr)] = apply_byte_sel(ref_mem[word_index(adr)], dat, sel);
  endtask

  task automatic ram_read_check(input string name, input addr_t adr);
    wb_rsp_t rsp;
    bus_single(adr, 1'b0, '0, '1, rsp);
    check_rsp_err(name, 1'b0, rsp.err);
    check_data(name, ref_mem[word_index(adr)], rsp.dat);
  endtask

  task automatic clint_write(input string name, input addr_t adr, input data_t dat);
    wb_rsp_t rsp;
    bus_single(adr, 1'b1, dat, '1, rsp);
    check_rsp_err(name, 1'b0, rsp.err);
  endtask

  task automatic clint_read(input string name, input addr_t adr, output data_t dat);
    wb_rsp_t rsp;
    bus_single(adr, 1'b0, '0, '1, rsp);
    check_rsp_err(name, 1'b0, rsp.err);
    dat = rsp.dat;
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic reset_and_single_words();
    check_flag("reset_timer_irq", 1'b0, timer_irq);
    check_flag("reset_sw_irq", 1'b0, sw_irq);
    for (int i = 0; i < 4; i++) begin
      ram_write("single_write", RAM_BASE + addr_t'(32'h100 + 4*i), 32'hC0DE_0000 + i, '1);
    end
    for (int i = 0; i < 4; i++) begin
      ram_read_check("single_read", RAM_BASE + addr_t'(32'h100 + 4*i));
    end
    // Partial write keeps the unselected bytes
    ram_write("partial_base", RAM_BASE + 32'h200, 32'h1122_3344, '1);
    ram_write("partial_merge", RAM_BASE + 32'h200, 32'hAABB_CCDD, 4'b0101);
    ram_read_check("partial_read", RAM_BASE + 32'h200);
  endtask

  task automatic burst_read_line();
    addr_t base;
    base = RAM_BASE + 32'h400;
    for (int i = 0; i <= WORDS_PER_LINE; i++) begin
      ram_write("burst_fill", base + addr_t'(4*i), 32'hB000_0000 ^ (i * 32'h0101_0101), '1);
    end
    read_burst("burst_read", base);
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      check_data("burst_beat", ref_mem[word_index(base + addr_t'(4*b))], burst_words[b]);
    end
    // Word of the next line, fetched fresh
    ram_read_check("after_burst", base + addr_t'(4*WORDS_PER_LINE));
  endtask

  task automatic unmapped_access();
    wb_rsp_t rsp;
    bus_single(32'h1000_0040, 1'b0, '0, '1, rsp);
    check_rsp_err("unmapped_err", 1'b1, rsp.err);
    check_flag("unmapped_ack", 1'b0, rsp.ack);
    check_data("unmapped_dat", '0, rsp.dat);
    ram_read_check("ram_after_unmapped", RAM_BASE + 32'h100);
  endtask

  task automatic software_irq();
    data_t rd;
    clint_write("msip_set", clint_addr(CLINT_MSIP_OFS), 32'h1);
    check_flag("sw_irq_high", 1'b1, sw_irq);
    clint_read("msip_read_set", clint_addr(CLINT_MSIP_OFS), rd);
    check_data("msip_read_set", 32'h1, rd);
    clint_write("msip_clear", clint_addr(CLINT_MSIP_OFS), 32'h0);
    check_flag("sw_irq_low", 1'b0, sw_irq);
    clint_read("msip_read_clear", clint_addr(CLINT_MSIP_OFS), rd);
    check_data("msip_read_clear", 32'h0, rd);
  endtask

  task automatic machine_timer();
    data_t t0;
    data_t t1;
    data_t cmp;
    clint_read("mtime_first", clint_addr(CLINT_MTIME_OFS), t0);
    clint_read("mtime_second", clint_addr(CLINT_MTIME_OFS), t1);
    check_flag("mtime_increasing", 1'b1, t1 > t0);
    // Compare of zero fires at once
    clint_write("mtimecmp_lo_zero", clint_addr(CLINT_MTIMECMP_OFS), '0);
    clint_write("mtimecmp_hi_zero", clint_addr(CLINT_MTIMECMP_OFS) + 4, '0);
    check_flag("timer_irq_set", 1'b1, timer_irq);
    // High word alone pushes the compare past mtime
    clint_write("mtimecmp_hi_ones", clint_addr(CLINT_MTIMECMP_OFS) + 4, '1);
    check_flag("timer_irq_clear", 1'b0, timer_irq);
    clint_write("mtimecmp_lo_ones", clint_addr(CLINT_MTIMECMP_OFS), '1);
    clint_read("mtimecmp_lo_read", clint_addr(CLINT_MTIMECMP_OFS), cmp);
    check_data("mtimecmp_lo_read", '1, cmp);
  endtask

  task automatic random_ram_traffic();
    addr_t adr;
    // Known contents first, so every read is predictable
    for (int i = 0; i < RAND_WORDS; i++) begin
      ram_write("random_preload", RAND_BASE + addr_t'(4*i), $urandom(), '1);
    end
    for (int n = 0; n < RAND_OPS; n++) begin
      adr = RAND_BASE + addr_t'(4 * $urandom_range(RAND_WORDS-1));
      if ($urandom_range(1) == 1) begin
        ram_write("random_write", adr, $urandom(), sel_t'($urandom_range(15)));
      end else begin
        ram_read_check("random_read", adr);
      end
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    rand_seed = 96;
    void'($urandom(rand_seed));
    wb_req    = '0;
    rst_n     = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    reset_and_single_words();
    burst_read_line();
    unmapped_access();
    software_irq();
    machine_timer();
    random_ram_traffic();
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- files.f
design/soc_pkg.sv
design/ram_line_store.sv
design/wb_addr_decoder.sv
design/wb_ram_adapter.sv
design/wb_clint.sv
design/soc_fabric_top.sv
dv/tb_soc_fabric.sv
